// File: all.f
+incdir+.
eth_rx_pkg.sv
rx_reset_seq.sv
rx_csr_regs.sv
rx_frame_stats.sv
eth_rx_top.sv
eth_rx_clk_gen.sv
eth_rx_assertions.sv
eth_rx_tb.sv

// File: eth_rx_assertions.sv
// RX monitor assertions
// CSR read latency and ready behavior around reset and lock loss

`timescale 1ns/1ns

module eth_rx_assertions (
    input logic                   rx_clk,
    input logic                   i_rst,
    input eth_rx_pkg::csr_req_t   i_csr,
    input eth_rx_pkg::rx_status_t i_status,
    input eth_rx_pkg::csr_rsp_t   i_csr_rsp,
    input logic                   i_rx_ready
);

    int fail_count = 0;                     // failed assertion tally

    // readvalid is the echo of a read one cycle earlier
    a_rv_echo: assert property (@(posedge rx_clk) disable iff (i_rst)
        i_csr_rsp.readvalid == $past(i_csr.read))
    else begin
        $error("readvalid does not follow the read strobe by exactly one cycle");
        fail_count++;
    end

    a_rst_ready: assert property (@(posedge rx_clk) i_rst |=> !i_rx_ready)
    else begin
        $error("rx ready is high the cycle after reset");
        fail_count++;
    end

    // link drops at the next edge once cdr lock goes away
    a_lock_loss: assert property (@(posedge rx_clk) disable iff (i_rst)
        (i_rx_ready && !i_status.cdr_lock) |=> !i_rx_ready)
    else begin
        $error("rx ready did not fall the cycle after cdr lock dropped");
        fail_count++;
    end

endmodule

bind eth_rx_top eth_rx_assertions eth_rx_assertions_inst (
    .rx_clk     (rx_clk),
    .i_rst      (i_rst),
    .i_csr      (i_csr),
    .i_status   (i_status),
    .i_csr_rsp  (o_csr),
    .i_rx_ready (o_rx_ready)
);

// File: eth_rx_clk_gen.sv
// testbench clock source
// free-running rx_clk, 4 ns period

`timescale 1ns/1ns

module eth_rx_clk_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #2 o_clk = ~o_clk;               // half period

endmodule

// File: eth_rx_consts.svh
// RX monitor constants
// widths, CSR address map, register defaults and reset sequencer timing

`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// ********************
// bus and register widths
`define RX_DATA_W       64              // 8 bytes per beat
`define RX_EMPTY_W      3               // unused bytes on eop beat
`define CSR_ADDR_W      16              // word address
`define CSR_DATA_W      32
`define CNT_W           32              // statistics counter width

// ********************
// CSR address map
`define ADDR_SCRATCH    16'h0000        // cfg region
`define ADDR_MAX_FRM    16'h0001
`define ADDR_STAT_GOOD  16'h0100        // stats window, write clears
`define ADDR_STAT_OVER  16'h0101
`define ADDR_STAT_RUNT  16'h0102
`define ADDR_RST_STAT   16'h0200        // bit0 soft reset / ready

// ********************
// defaults and limits
`define MAX_FRM_DEFAULT 1518            // std max untagged frame
`define MIN_FRM_LEN     64              // shorter frames are runts
`define RST_HOLD_CYCLES 16              // mac reset hold time
`define UNMAPPED_DATA   32'hdead_c0de   // read value for holes

`endif

// File: eth_rx_pkg.sv
// RX monitor shared types
// beat, PHY status, CSR request/response, counter bundle and FSM encodings

`include "eth_rx_consts.svh"

package eth_rx_pkg;

    // ********************
    // streaming bus
    typedef struct packed {
        logic                   valid;      // beat qualifier
        logic                   sop;        // first beat of frame
        logic                   eop;        // last beat of frame
        logic [`RX_EMPTY_W-1:0] empty;      // pad bytes on eop beat
        logic [`RX_DATA_W-1:0]  data;       // 8 payload bytes
    } rx_beat_t;

    // PHY status levels, cdr_lock is the msb
    typedef struct packed {
        logic cdr_lock;                     // cdr locked to data
        logic pcs_ready;                    // pcs fully aligned
        logic block_lock;                   // 66b block lock
        logic am_lock;                      // alignment marker lock
        logic hi_ber;                       // high bit error rate
    } rx_status_t;

    // ********************
    // CSR port
    typedef struct packed {
        logic                   write;      // one-cycle strobe
        logic                   read;       // one-cycle strobe
        logic [`CSR_ADDR_W-1:0] address;    // word address
        logic [`CSR_DATA_W-1:0] writedata;
    } csr_req_t;

    typedef struct packed {
        logic                   readvalid;  // one cycle after read
        logic [`CSR_DATA_W-1:0] readdata;
    } csr_rsp_t;

    // statistics bundle
    typedef struct packed {
        logic [`CNT_W-1:0] good;            // in-range frames
        logic [`CNT_W-1:0] oversize;        // longer than max_frm
        logic [`CNT_W-1:0] runt;            // shorter than min
    } rx_counters_t;

    // ********************
    // encodings
    typedef enum logic [1:0] {
        ST_HOLD,                            // mac held in reset
        ST_WAIT_CDR,                        // waiting for cdr lock
        ST_WAIT_PCS,                        // waiting for pcs align
        ST_READY                            // link up
    } rst_state_e;

    typedef enum logic [1:0] {
        CLS_GOOD,
        CLS_OVER,
        CLS_RUNT
    } frm_class_e;

endpackage

// File: eth_rx_tb.sv
// RX monitor testbench
// table-driven CSR, frame and PHY status stimulus against a model of the counters

`timescale 1ns/1ns
`include "eth_rx_consts.svh"

module eth_rx_tb;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_FRM, OP_STAT, OP_IDLE, OP_READY} op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] arg;                   // address, frame length or cycles
        logic [31:0] data;                  // write data or status bits
        logic [31:0] exp;                   // read data or ready level
    } step_t;

    logic                     rx_clk;
    logic                     rst;
    eth_rx_pkg::rx_status_t   status;
    eth_rx_pkg::rx_beat_t     rx_beat;
    eth_rx_pkg::csr_req_t     csr_req;
    eth_rx_pkg::csr_rsp_t     csr_rsp;
    logic                     rx_ready;
    step_t                    steps[$];
    logic [31:0]              rng;          // xorshift state
    eth_rx_pkg::rx_counters_t model;        // expected counters
    logic [15:0]              model_max;    // expected max frame length
    logic                     link_up;      // expected ready level
    int                       n_checks;
    int                       n_errors;
    int                       cycle_cnt;
    int                       timeout_limit;

    eth_rx_clk_gen eth_rx_clk_gen_inst (.o_clk(rx_clk));

    eth_rx_top eth_rx_top_inst (
        .rx_clk     (rx_clk),
        .i_rst      (rst),
        .i_status   (status),
        .i_rx       (rx_beat),
        .i_csr      (csr_req),
        .o_csr      (csr_rsp),
        .o_rx_ready (rx_ready)
    );

    // ********************
    // compare tasks
    task automatic check_rsp(input eth_rx_pkg::csr_rsp_t got, input eth_rx_pkg::csr_rsp_t exp,
                             input string what);
        n_checks++;
        if (got.readvalid !== exp.readvalid
            || (exp.readvalid && got.readdata !== exp.readdata)) begin
            n_errors++;
            $display("Fail %0t: %s, got %0b/%h expected %0b/%h", $time, what,
                     got.readvalid, got.readdata, exp.readvalid, exp.readdata);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %0t: %s, got %0b expected %0b", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ********************
    // bus drivers on the falling edge
    task automatic csr_write(input logic [15:0] addr, input logic [31:0] data);
        csr_req           = '0;
        csr_req.write     = 1'b1;
        csr_req.address   = addr;
        csr_req.writedata = data;
        @(negedge rx_clk);
        csr_req = '0;
        @(negedge rx_clk);                  // clear pulse has landed
        if (addr == `ADDR_MAX_FRM) begin
            model_max = data[15:0];
        end
        if (addr[15:8] == 8'h01) begin
            model = '0;                     // whole stats window clears
        end
    endtask

    task automatic csr_read(input logic [15:0] addr, input logic [31:0] exp_data);
        eth_rx_pkg::csr_rsp_t exp_rsp;
        csr_req         = '0;
        csr_req.read    = 1'b1;
        csr_req.address = addr;
        @(negedge rx_clk);
        csr_req           = '0;
        exp_rsp.readvalid = 1'b1;           // one cycle after the strobe
        exp_rsp.readdata  = exp_data;
        check_rsp(csr_rsp, exp_rsp, $sformatf("read of %04h", addr));
        @(negedge rx_clk);
        exp_rsp.readvalid = 1'b0;           // and only for that cycle
        check_rsp(csr_rsp, exp_rsp, $sformatf("readvalid drop after %04h", addr));
    endtask

    task automatic send_frame(input int len);
        int beats;
        beats = (len + 7) / 8;
        for (int i = 0; i < beats; i++) begin
            rx_beat       = '0;
            rx_beat.valid = 1'b1;
            rx_beat.sop   = (i == 0);
            rx_beat.eop   = (i == beats - 1);
            rx_beat.data  = {next_rand(), next_rand()};
            rx_beat.empty = rx_beat.eop ? 3'(beats * 8 - len)          // pad bytes
                                        : rx_beat.data[2:0];           // don't care off eop
            @(negedge rx_clk);
        end
        rx_beat = '0;
        @(negedge rx_clk);                  // counter update lands
        if (link_up) begin
            if (len < `MIN_FRM_LEN) begin
                model.runt = model.runt + 1;
            end else if (len > model_max) begin
                model.oversize = model.oversize + 1;
            end else begin
                model.good = model.good + 1;
            end
        end
    endtask

    // ********************
    // table
    function automatic void add_step(input op_e op, input int arg, input logic [31:0] data,
                                     input logic [31:0] exp);
        steps.push_back(step_t'{op, arg[15:0], data, exp});
    endfunction

    function automatic void build_table();
        int lens[5] = '{60, 64, 1518, 1519, 300};
        add_step(OP_IDLE, 30, 0, 0);                        // hold over without cdr lock
        add_step(OP_STAT, 0, 32'h10, 0);                    // cdr lock only
        add_step(OP_IDLE, 20, 0, 0);                        // still waiting on pcs
        add_step(OP_STAT, 0, 32'h1e, 0);                    // pcs, block, am lock
        add_step(OP_READY, 0, 0, 1);
        add_step(OP_RD, `ADDR_RST_STAT, 0, 32'h3d);         // ready + raw status
        add_step(OP_WR, `ADDR_SCRATCH, 32'ha5c3_1e78, 0);
        add_step(OP_RD, `ADDR_SCRATCH, 0, 32'ha5c3_1e78);
        add_step(OP_RD, `ADDR_MAX_FRM, 0, `MAX_FRM_DEFAULT);
        add_step(OP_RD, 16'h0042, 0, `UNMAPPED_DATA);       // hole in cfg region
        foreach (lens[i]) begin
            add_step(OP_FRM, lens[i], 0, 0);
        end
        repeat (6) begin
            add_step(OP_FRM, 0, 0, 0);                      // length 0 draws a random one
        end
        add_step(OP_RD, `ADDR_STAT_GOOD, 0, 0);
        add_step(OP_RD, `ADDR_STAT_OVER, 0, 0);
        add_step(OP_RD, `ADDR_STAT_RUNT, 0, 0);
        add_step(OP_WR, `ADDR_MAX_FRM, 256, 0);
        add_step(OP_RD, `ADDR_MAX_FRM, 0, 256);
        add_step(OP_FRM, 300, 0, 0);                        // now oversize
        add_step(OP_RD, `ADDR_STAT_OVER, 0, 0);
        add_step(OP_WR, `ADDR_STAT_GOOD, 0, 0);             // clear all
        add_step(OP_RD, `ADDR_STAT_GOOD, 0, 0);
        add_step(OP_RD, `ADDR_STAT_OVER, 0, 0);
        add_step(OP_RD, `ADDR_STAT_RUNT, 0, 0);
        add_step(OP_FRM, 100, 0, 0);
        add_step(OP_WR, `ADDR_RST_STAT, 1, 0);              // soft reset
        add_step(OP_READY, 0, 0, 0);
        add_step(OP_FRM, 64, 0, 0);                         // dropped in reset
        add_step(OP_RD, `ADDR_STAT_GOOD, 0, 0);
        add_step(OP_READY, 0, 0, 1);
        add_step(OP_STAT, 0, 32'h0e, 0);                    // lose cdr lock
        add_step(OP_IDLE, 0, 0, 0);                         // ready already low
        add_step(OP_FRM, 64, 0, 0);
        add_step(OP_RD, `ADDR_STAT_GOOD, 0, 0);
        add_step(OP_STAT, 0, 32'h1e, 0);
        add_step(OP_READY, 0, 0, 1);
        add_step(OP_RD, `ADDR_RST_STAT, 0, 32'h3d);
    endfunction

    function automatic int step_cycles(input step_t s);
        case (s.op)
            OP_WR, OP_RD: return 2;
            OP_FRM:       return (s.arg == 0) ? 202 : (s.arg + 7) / 8 + 1;
            OP_STAT:      return 1;
            OP_IDLE:      return s.arg;
            default:      return 100;           // ready poll bound
        endcase
    endfunction

    task automatic run_step(input step_t s);
        int          polls;
        logic [31:0] exp_data;
        case (s.op)
            OP_WR: csr_write(s.arg, s.data);
            OP_RD: begin
                case (s.arg)
                    `ADDR_STAT_GOOD: exp_data = model.good;
                    `ADDR_STAT_OVER: exp_data = model.oversize;
                    `ADDR_STAT_RUNT: exp_data = model.runt;
                    default:         exp_data = s.exp;
                endcase
                csr_read(s.arg, exp_data);
            end
            OP_FRM: send_frame(s.arg != 0 ? int'(s.arg) : 40 + int'(next_rand() % 1560));
            OP_STAT: begin
                status = eth_rx_pkg::rx_status_t'(s.data[4:0]);
                @(negedge rx_clk);
                link_up = link_up && status.cdr_lock;
            end
            OP_IDLE: begin
                repeat (s.arg) @(negedge rx_clk);
                check_ready(rx_ready, s.exp[0], "ready level after idle");
                link_up = s.exp[0];
            end
            default: begin                      // bounded wait on the ready level
                polls = 0;
                while (rx_ready !== s.exp[0] && polls < 100) begin
                    @(negedge rx_clk);
                    polls++;
                end
                check_ready(rx_ready, s.exp[0], "ready level after poll");
                link_up = s.exp[0];
            end
        endcase
    endtask

    // ********************
    // run limit
    always @(posedge rx_clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout: test did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int total;
        int n_assert;
        rst       = 1'b1;
        status    = '0;
        rx_beat   = '0;
        csr_req   = '0;
        rng       = 32'h8e30_fe90;
        model     = '0;
        model_max = 16'(`MAX_FRM_DEFAULT);
        link_up   = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        cycle_cnt = 0;
        build_table();
        total = 10;                             // reset cycles
        foreach (steps[i]) begin
            total += step_cycles(steps[i]);
        end
        timeout_limit = 4 * total + 200;
        repeat (10) @(posedge rx_clk);
        @(negedge rx_clk);
        rst = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        n_assert = eth_rx_top_inst.eth_rx_assertions_inst.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: eth_rx_top.sv
// RX monitor top level
// ties the reset sequencer, CSR block and frame statistics together on rx_clk

`timescale 1ns/1ns

module eth_rx_top (
    input  logic                   rx_clk,
    input  logic                   i_rst,
    input  eth_rx_pkg::rx_status_t i_status,     // phy status levels
    input  eth_rx_pkg::rx_beat_t   i_rx,         // receive beats
    input  eth_rx_pkg::csr_req_t   i_csr,
    output eth_rx_pkg::csr_rsp_t   o_csr,
    output logic                   o_rx_ready
);

    logic                     soft_rst;          // csr -> sequencer
    logic                     stats_clr;         // csr -> stats
    logic [15:0]              max_frm;           // csr -> stats
    logic                     mac_rst;           // sequencer -> stats
    logic                     rx_ready;          // sequencer -> csr, port
    eth_rx_pkg::rx_counters_t counters;          // stats -> csr

    // ********************
    // reset sequencer
    rx_reset_seq rx_reset_seq_inst (
        .rx_clk     (rx_clk),
        .i_rst      (i_rst),
        .i_status   (i_status),
        .i_soft_rst (soft_rst),
        .o_mac_rst  (mac_rst),
        .o_rx_ready (rx_ready)
    );

    // ********************
    // register file
    rx_csr_regs rx_csr_regs_inst (
        .rx_clk      (rx_clk),
        .i_rst       (i_rst),
        .i_csr       (i_csr),
        .i_status    (i_status),                 // raw, read back in 5:1
        .i_rx_ready  (rx_ready),
        .i_counters  (counters),
        .o_csr       (o_csr),
        .o_max_frm   (max_frm),
        .o_soft_rst  (soft_rst),
        .o_stats_clr (stats_clr)
    );

    // ********************
    // frame statistics
    rx_frame_stats rx_frame_stats_inst (
        .rx_clk      (rx_clk),
        .i_rst       (i_rst),
        .i_mac_rst   (mac_rst),                  // beats ignored while high
        .i_rx        (i_rx),
        .i_max_frm   (max_frm),
        .i_stats_clr (stats_clr),
        .o_counters  (counters)
    );

    assign o_rx_ready = rx_ready;

endmodule

// File: rx_csr_regs.sv
// RX monitor CSR block
// decodes cfg, stats and reset regions, holds scratch and max frame length,
// and returns read data with a fixed one-cycle latency

`timescale 1ns/1ns
`include "eth_rx_consts.svh"

module rx_csr_regs (
    input  logic                     rx_clk,
    input  logic                     i_rst,
    input  eth_rx_pkg::csr_req_t     i_csr,
    input  eth_rx_pkg::rx_status_t   i_status,
    input  logic                     i_rx_ready,
    input  eth_rx_pkg::rx_counters_t i_counters,
    output eth_rx_pkg::csr_rsp_t     o_csr,
    output logic [15:0]              o_max_frm,
    output logic                     o_soft_rst,
    output logic                     o_stats_clr
);

    logic                   sel_cfg;            // 0x00xx
    logic                   sel_stat;           // 0x01xx
    logic                   sel_rst;            // 0x02xx
    logic [`CSR_DATA_W-1:0] scratch;
    logic [15:0]            max_frm;
    logic [`CSR_DATA_W-1:0] rdata_nxt;          // read mux output
    logic [`CSR_DATA_W-1:0] rst_stat_word;      // ready + raw phy bits
    logic                   wr_scratch;
    logic                   wr_max_frm;
    logic                   wr_soft_rst;
    logic                   wr_stats;

    // ********************
    // region decode on the upper address byte
    assign sel_cfg  = (i_csr.address[15:8] == `ADDR_SCRATCH >> 8);
    assign sel_stat = (i_csr.address[15:8] == `ADDR_STAT_GOOD >> 8);
    assign sel_rst  = (i_csr.address[15:8] == `ADDR_RST_STAT >> 8);

    assign wr_scratch  = i_csr.write && sel_cfg
                         && (i_csr.address[7:0] == (`ADDR_SCRATCH & 16'h00ff));
    assign wr_max_frm  = i_csr.write && sel_cfg
                         && (i_csr.address[7:0] == (`ADDR_MAX_FRM & 16'h00ff));
    assign wr_soft_rst = i_csr.write && sel_rst
                         && (i_csr.address[7:0] == (`ADDR_RST_STAT & 16'h00ff))
                         && i_csr.writedata[0];            // only bit0 acts
    assign wr_stats    = i_csr.write && sel_stat;          // any stats addr clears

    // ********************
    // config registers and control pulses
    always_ff @(posedge rx_clk) begin
        if (i_rst) begin
            scratch     <= '0;
            max_frm     <= 16'(`MAX_FRM_DEFAULT);
            o_soft_rst  <= 1'b0;
            o_stats_clr <= 1'b0;
        end else begin
            if (wr_scratch) begin
                scratch <= i_csr.writedata;
            end
            if (wr_max_frm) begin
                max_frm <= i_csr.writedata[15:0];          // upper half ignored
            end
            o_soft_rst  <= wr_soft_rst;                    // single-cycle pulse
            o_stats_clr <= wr_stats;
        end
    end

    assign o_max_frm = max_frm;

    // status word with ready in bit0 and phy levels in 5:1
    assign rst_stat_word = {{(`CSR_DATA_W - 6){1'b0}}, i_status, i_rx_ready};

    // ********************
    // read mux
    always_comb begin
        case (i_csr.address)
            `ADDR_SCRATCH:   rdata_nxt = scratch;
            `ADDR_MAX_FRM:   rdata_nxt = {16'h0000, max_frm};
            `ADDR_STAT_GOOD: rdata_nxt = i_counters.good;
            `ADDR_STAT_OVER: rdata_nxt = i_counters.oversize;
            `ADDR_STAT_RUNT: rdata_nxt = i_counters.runt;
            `ADDR_RST_STAT:  rdata_nxt = rst_stat_word;
            default:         rdata_nxt = `UNMAPPED_DATA;   // holes
        endcase
    end

    // valid comes back exactly one cycle after the strobe
    always_ff @(posedge rx_clk) begin
        if (i_rst) begin
            o_csr.readvalid <= 1'b0;
        end else begin
            o_csr.readvalid <= i_csr.read;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (i_csr.read) begin
            o_csr.readdata <= rdata_nxt;                   // hold between reads
        end
    end

endmodule

// File: rx_frame_stats.sv
// RX frame statistics
// measures each frame from its beats and eop empty count,
// then bumps the good, oversize or runt counter

`timescale 1ns/1ns
`include "eth_rx_consts.svh"

module rx_frame_stats (
    input  logic                     rx_clk,
    input  logic                     i_rst,
    input  logic                     i_mac_rst,
    input  eth_rx_pkg::rx_beat_t     i_rx,
    input  logic [15:0]              i_max_frm,
    input  logic                     i_stats_clr,
    output eth_rx_pkg::rx_counters_t o_counters
);

    logic                     in_frame;         // sop seen, eop pending
    logic [15:0]              frm_len;          // bytes so far
    logic [3:0]               beat_bytes;       // 1..8 valid bytes
    logic [16:0]              len_sum;          // one extra bit for overflow
    logic [15:0]              len_nxt;          // saturated running length
    logic                     beat_ok;          // beat we act on
    logic                     frm_end;          // eop closing a tracked frame
    eth_rx_pkg::frm_class_e   frm_class;
    eth_rx_pkg::rx_counters_t counters;

    // ********************
    // length arithmetic
    assign beat_ok    = i_rx.valid && !i_mac_rst;            // ignored in reset
    assign beat_bytes = i_rx.eop ? 4'd8 - {1'b0, i_rx.empty} : 4'd8;   // empty only on eop
    assign len_sum    = {1'b0, (i_rx.sop ? 16'd0 : frm_len)} + {13'd0, beat_bytes};
    assign len_nxt    = len_sum[16] ? 16'hffff : len_sum[15:0];   // clamp huge frames

    // eop counts only for a frame we saw start
    assign frm_end = beat_ok && i_rx.eop && (i_rx.sop || in_frame);

    // ********************
    // classify on the final length
    always_comb begin
        if (len_nxt < 16'(`MIN_FRM_LEN)) begin
            frm_class = eth_rx_pkg::CLS_RUNT;
        end else if (len_nxt > i_max_frm) begin
            frm_class = eth_rx_pkg::CLS_OVER;
        end else begin
            frm_class = eth_rx_pkg::CLS_GOOD;
        end
    end

    // ********************
    // frame tracking
    always_ff @(posedge rx_clk) begin
        if (i_rst) begin
            in_frame <= 1'b0;
        end else if (i_mac_rst) begin
            in_frame <= 1'b0;                               // partial frame dropped
        end else if (beat_ok) begin
            if (i_rx.eop) begin
                in_frame <= 1'b0;
            end else if (i_rx.sop) begin
                in_frame <= 1'b1;                           // sop restarts any open frame
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (beat_ok && (i_rx.sop || in_frame)) begin
            frm_len <= len_nxt;
        end
    end

    // ********************
    // counters with clear beating increment
    always_ff @(posedge rx_clk) begin
        if (i_rst || i_stats_clr) begin
            counters <= '0;
        end else if (frm_end) begin
            case (frm_class)
                eth_rx_pkg::CLS_RUNT: counters.runt     <= counters.runt + 1'b1;
                eth_rx_pkg::CLS_OVER: counters.oversize <= counters.oversize + 1'b1;
                default:              counters.good     <= counters.good + 1'b1;
            endcase
        end
    end

    assign o_counters = counters;

endmodule

// File: rx_reset_seq.sv
// RX reset sequencer
// holds the MAC in reset, then waits for CDR lock and PCS alignment.
// Soft reset or loss of CDR lock sends it back to the hold state.

`timescale 1ns/1ns
`include "eth_rx_consts.svh"

module rx_reset_seq (
    input  logic                   rx_clk,
    input  logic                   i_rst,
    input  eth_rx_pkg::rx_status_t i_status,
    input  logic                   i_soft_rst,      // one-cycle pulse from csr
    output logic                   o_mac_rst,
    output logic                   o_rx_ready
);

    eth_rx_pkg::rst_state_e state;                  // current state
    eth_rx_pkg::rst_state_e state_nxt;
    logic [4:0]             hold_cnt;               // cycles spent in hold
    logic                   hold_done;

    assign hold_done = (hold_cnt == 5'(`RST_HOLD_CYCLES - 1));   // last hold cycle

    // ********************
    // next state
    always_comb begin
        state_nxt = state;
        if (i_soft_rst) begin
            state_nxt = eth_rx_pkg::ST_HOLD;        // restart from any state
        end else begin
            case (state)
                eth_rx_pkg::ST_HOLD: begin
                    if (hold_done) begin
                        state_nxt = eth_rx_pkg::ST_WAIT_CDR;
                    end
                end
                eth_rx_pkg::ST_WAIT_CDR: begin
                    if (i_status.cdr_lock) begin
                        state_nxt = eth_rx_pkg::ST_WAIT_PCS;
                    end
                end
                eth_rx_pkg::ST_WAIT_PCS: begin
                    if (!i_status.cdr_lock) begin
                        state_nxt = eth_rx_pkg::ST_HOLD;    // lock lost before align
                    end else if (i_status.pcs_ready) begin
                        state_nxt = eth_rx_pkg::ST_READY;
                    end
                end
                default: begin                      // ST_READY
                    if (!i_status.cdr_lock) begin
                        state_nxt = eth_rx_pkg::ST_HOLD;
                    end
                end
            endcase
        end
    end

    // ********************
    // state and hold counter
    always_ff @(posedge rx_clk) begin
        if (i_rst) begin
            state    <= eth_rx_pkg::ST_HOLD;
            hold_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state != eth_rx_pkg::ST_HOLD || i_soft_rst) begin
                hold_cnt <= '0;                     // rearm for next entry
            end else if (!hold_done) begin
                hold_cnt <= hold_cnt + 5'd1;
            end
        end
    end

    // outputs decode straight from the state register
    assign o_mac_rst  = (state != eth_rx_pkg::ST_READY);
    assign o_rx_ready = (state == eth_rx_pkg::ST_READY);

endmodule
